//--- rtl/mac_cfg_pkg.sv
`default_nettype none

// ************************************************************************
// fixed widths of the memory access controller
// ************************************************************************

package mac_cfg_pkg;

  // internal data bus fidbo.
  localparam int bus_w = 16;

  // segment number held in the seg register.
  localparam int seg_w = 8;

  // virtual page field carried by a lookup.
  localparam int page_w = 6;

  // ring field at the bottom of pcr.
  localparam int ring_w = 2;

  // ************************************************************************
  // privilege
  // ************************************************************************

  // ring 3 is the supervisor and alone may reload exm and pcr once paging is on.
  localparam logic [ring_w-1:0] sup_ring = 2'd3;

endpackage

`default_nettype wire

//--- rtl/mac_regs_pkg.sv
`default_nettype none

package mac_regs_pkg;

  import mac_cfg_pkg::*;

  // ************************************************************************
  // microcode load field
  // ************************************************************************

  typedef enum logic [1:0] {
    ld_none = 2'd0,                  // no register load.
    ld_exm  = 2'd1,                  // extension mode, privileged.
    ld_pcr  = 2'd2,                  // paging control, privileged.
    ld_seg  = 2'd3                   // segment number, always allowed.
  } ld_cmd_e;

  typedef struct packed {
    logic exm;                       // load exm from fidbo[2:0].
    logic pcr;                       // load pcr from fidbo[15:7,2:0].
    logic seg;                       // load seg from fidbo[7:0].
  } ld_strobe_t;

  // ************************************************************************
  // register images
  // ************************************************************************

  typedef struct packed {
    logic [1:0] xpt;                 // page extension, bus bits 2:1.
    logic       pex;                 // physical extension enable, bus bit 0.
  } exm_t;

  typedef struct packed {
    logic              pce;          // paging control enable, bit 15.
    logic [3:0]        lev;          // interrupt level, bits 14:11.
    logic [1:0]        npt;          // normal page table, bits 10:9.
    logic [1:0]        apt;          // alternate page table, bits 8:7.
    logic [3:0]        rsv;          // reads zero, bits 6:3.
    logic              ppc;          // page protection check, bit 2.
    logic [ring_w-1:0] ring;         // current ring, bits 1:0.
  } pcr_t;

  typedef struct packed {
    logic              valid;        // one cycle pulse per lookup.
    logic [1:0]        ext;          // page extension, zero unless vex.
    logic [1:0]        pt;           // selected page table.
    logic [seg_w-1:0]  seg;          // segment at lookup time.
    logic [page_w-1:0] page;         // virtual page of the lookup.
  } pt_ref_t;

endpackage

`default_nettype wire

//--- rtl/mac_load_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mac_load_decode (
  input  wire                       mclk,
  input  wire                       reset,
  input  wire mac_regs_pkg::ld_cmd_e ld_cmd,     // microcode load field.
  input  wire mac_regs_pkg::pcr_t    pcr,        // current pcr for the ring check.
  output mac_regs_pkg::ld_strobe_t   ld,         // granted load strobes.
  output logic                       priv_viol   // one cycle after a refused load.
);

  import mac_cfg_pkg::*;
  import mac_regs_pkg::*;

  logic priv_ok;                                 // privileged loads allowed now.
  logic refused;                                 // this cycle's load is dropped.

  // unpaged machine or supervisor ring.
  assign priv_ok = !pcr.pce || (pcr.ring == sup_ring);

  // ************************************************************************
  // load field decode
  // ************************************************************************

  always_comb begin
    ld      = '0;                                // default no strobe.
    refused = 1'b0;
    case (ld_cmd)
      ld_exm: begin
        ld.exm  = priv_ok;                       // suppressed outside ring 3.
        refused = !priv_ok;
      end
      ld_pcr: begin
        ld.pcr  = priv_ok;
        refused = !priv_ok;
      end
      ld_seg:  ld.seg = 1'b1;                    // segment loads are never checked.
      default: ld = '0;                          // ld_none.
    endcase
  end

  always_ff @(posedge mclk) begin
    if (reset) begin
      priv_viol <= 1'b0;
    end else begin
      priv_viol <= refused;                      // one pulse per refusal.
    end
  end

  a_ld_onehot: assert property (@(posedge mclk) disable iff (reset) $onehot0(ld));

endmodule

`default_nettype wire

//--- rtl/mac_segpt.sv
`timescale 1ns/1ps
`default_nettype none

module mac_segpt (
  input  wire                              mclk,
  input  wire                              reset,
  input  wire                              ext_mode,   // cpu extended-mode state.
  input  wire [mac_cfg_pkg::bus_w-1:0]     fidbo,      // internal data bus.
  input  wire mac_regs_pkg::ld_strobe_t    ld,         // granted load strobes.
  output mac_regs_pkg::pcr_t               pcr,        // paging control register.
  output mac_regs_pkg::exm_t               exm,        // extension mode register.
  output logic [mac_cfg_pkg::seg_w-1:0]    seg,        // segment register.
  output logic                             seg_zero_n, // high when seg nonzero.
  output logic                             pex,        // physical extension enable.
  output logic                             vex,        // extension in effect.
  output logic [1:0]                       xpt         // page extension bits.
);

  import mac_cfg_pkg::*;
  import mac_regs_pkg::*;

  // ************************************************************************
  // control registers
  // ************************************************************************

  // exm, bus bits 2:0.
  always_ff @(posedge mclk) begin
    if (reset) begin
      exm <= '0;
    end else if (ld.exm) begin
      exm <= exm_t'(fidbo[2:0]);                 // xpt from 2:1, pex from 0.
    end
  end

  // seg, bus bits 7:0.
  always_ff @(posedge mclk) begin
    if (reset) begin
      seg <= '0;
    end else if (ld.seg) begin
      seg <= fidbo[seg_w-1:0];
    end
  end

  // pcr, bus bits 15:7 and 2:0.
  always_ff @(posedge mclk) begin
    if (reset) begin
      pcr <= '0;
    end else if (ld.pcr) begin
      pcr <= pcr_t'({fidbo[15:7], 4'b0000, fidbo[2:0]});  // hole at 6:3 reads zero.
    end
  end

  // ************************************************************************
  // derived flags
  // ************************************************************************

  assign seg_zero_n = |seg;                      // low for segment zero.
  assign pex        = exm.pex;
  assign xpt        = exm.xpt;
  assign vex        = exm.pex & ext_mode;        // extension only in extended mode.

  // reserved field stays clear whatever fidbo carried.
  a_pcr_rsv: assert property (@(posedge mclk) disable iff (reset) pcr.rsv == '0);

endmodule

`default_nettype wire

//--- rtl/mac_pt_select.sv
`timescale 1ns/1ps
`default_nettype none

module mac_pt_select (
  input  wire                           mclk,
  input  wire                           reset,
  input  wire                           lookup,   // one request per cycle.
  input  wire                           alt,      // use the alternate page table.
  input  wire [mac_cfg_pkg::page_w-1:0] vpage,    // virtual page of the request.
  input  wire mac_regs_pkg::pcr_t       pcr,      // current paging control.
  input  wire mac_regs_pkg::exm_t       exm,      // current extension mode.
  input  wire [mac_cfg_pkg::seg_w-1:0]  seg,      // current segment.
  input  wire                           vex,      // extension in effect.
  output mac_regs_pkg::pt_ref_t         pt_ref    // registered reference.
);

  import mac_cfg_pkg::*;
  import mac_regs_pkg::*;

  logic [1:0] pt_sel;                             // table chosen by alt.
  logic [1:0] ext_sel;                            // extension, gated by vex.

  // ************************************************************************
  // reference forming
  // ************************************************************************

  always_comb begin
    pt_sel  = alt ? pcr.apt : pcr.npt;            // alternate or normal table.
    ext_sel = vex ? exm.xpt : 2'b00;              // no extension outside vex.
  end

  // ************************************************************************
  // output stage
  // ************************************************************************

  // registers still hold their pre-edge value here, so a load in the
  // same cycle as the lookup is not seen.
  always_ff @(posedge mclk) begin
    if (reset) begin
      pt_ref.valid <= 1'b0;
    end else begin
      pt_ref.valid <= lookup;                     // one pulse per request.
    end
    if (lookup) begin                             // payload held between lookups.
      pt_ref.ext  <= ext_sel;
      pt_ref.pt   <= pt_sel;
      pt_ref.seg  <= seg;
      pt_ref.page <= vpage;
    end
  end

  a_valid_after_reset: assert property (@(posedge mclk) reset |=> !pt_ref.valid);

endmodule

`default_nettype wire

//--- rtl/mac_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac_top (
  input  wire                           mclk,
  input  wire                           reset,
  input  wire                           ext_mode,   // cpu extended-mode state.
  input  wire [mac_cfg_pkg::bus_w-1:0]  fidbo,      // internal data bus.
  input  wire mac_regs_pkg::ld_cmd_e    ld_cmd,     // microcode load field.
  input  wire                           lookup,     // page-table lookup strobe.
  input  wire                           alt,        // alternate table select.
  input  wire [mac_cfg_pkg::page_w-1:0] vpage,      // lookup virtual page.
  output wire mac_regs_pkg::pcr_t       pcr,
  output wire [mac_cfg_pkg::seg_w-1:0]  seg,
  output wire                           seg_zero_n,
  output wire                           pex,
  output wire                           vex,
  output wire [1:0]                     xpt,
  output wire                           priv_viol,
  output wire mac_regs_pkg::pt_ref_t    pt_ref
);

  import mac_regs_pkg::*;

  ld_strobe_t ld;                                   // decoder to register block.
  exm_t       exm;                                  // register block to selector.

  mac_load_decode u_load_decode (
    .mclk      (mclk),
    .reset     (reset),
    .ld_cmd    (ld_cmd),
    .pcr       (pcr),                               // ring check uses live pcr.
    .ld        (ld),
    .priv_viol (priv_viol)
  );

  mac_segpt u_segpt (
    .mclk       (mclk),
    .reset      (reset),
    .ext_mode   (ext_mode),
    .fidbo      (fidbo),
    .ld         (ld),
    .pcr        (pcr),
    .exm        (exm),
    .seg        (seg),
    .seg_zero_n (seg_zero_n),
    .pex        (pex),
    .vex        (vex),
    .xpt        (xpt)
  );

  mac_pt_select u_pt_select (
    .mclk   (mclk),
    .reset  (reset),
    .lookup (lookup),
    .alt    (alt),
    .vpage  (vpage),
    .pcr    (pcr),
    .exm    (exm),
    .seg    (seg),
    .vex    (vex),
    .pt_ref (pt_ref)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic mclk,                             // 40 ns period.
  output logic reset                             // high for the first 8 cycles.
);

  initial begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge mclk);
    @(negedge mclk);                             // release away from the sampling edge.
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- test/tb_mac_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_top;

  import mac_cfg_pkg::*;
  import mac_regs_pkg::*;

  logic mclk, reset, ext_mode, lookup, alt;
  logic [bus_w-1:0]  fidbo;
  ld_cmd_e           ld_cmd;
  logic [page_w-1:0] vpage;
  pcr_t              pcr;
  logic [seg_w-1:0]  seg;
  logic              seg_zero_n, pex, vex, priv_viol;
  logic [1:0]        xpt;
  pt_ref_t           pt_ref;

  pcr_t              m_pcr;                      // shadow registers.
  exm_t              m_exm;
  logic [seg_w-1:0]  m_seg;
  logic              m_viol;                     // expected priv_viol next cycle.
  pt_ref_t           m_ref;                      // expected pt_ref next cycle.
  logic              armed;                      // set once reset has been sampled.
  int                errors, timeouts, lookups_sent, refs_seen;

  tb_clock u_clock (.mclk(mclk), .reset(reset));

  mac_top dut0 (
    .mclk(mclk), .reset(reset), .ext_mode(ext_mode), .fidbo(fidbo), .ld_cmd(ld_cmd),
    .lookup(lookup), .alt(alt), .vpage(vpage), .pcr(pcr), .seg(seg),
    .seg_zero_n(seg_zero_n), .pex(pex), .vex(vex), .xpt(xpt), .priv_viol(priv_viol),
    .pt_ref(pt_ref)
  );

  // reference for one lookup against the registers as they stood.
  function automatic pt_ref_t expect_ref(pcr_t p, exm_t x, logic [seg_w-1:0] s,
                                         logic em, logic a, logic [page_w-1:0] vp);
    pt_ref_t r;
    r.valid = 1'b1;
    r.pt    = a ? p.apt : p.npt;                 // alternate or normal table.
    r.ext   = (x.pex && em) ? x.xpt : 2'b00;     // no extension without vex.
    r.seg   = s;
    r.page  = vp;
    return r;
  endfunction

  task automatic flag_value(string what, logic [31:0] got, logic [31:0] want);
    errors++;
    $display("FAILED at %0d ns: %s reads %0h, expected %0h", $time, what, got, want);
  endtask

  // ************************************************************************
  // compare process and shadow model
  // ************************************************************************

  always @(posedge mclk) begin : compare
    logic priv_ok;
    if (armed) begin                             // outputs still hold pre-edge values.
      assert (pcr == m_pcr) else flag_value("pcr", pcr, m_pcr);
      assert (seg == m_seg) else flag_value("seg", seg, m_seg);
      assert (seg_zero_n == (m_seg != 0))
        else flag_value("seg_zero_n", seg_zero_n, m_seg != 0);
      assert (pex == m_exm.pex) else flag_value("pex", pex, m_exm.pex);
      assert (xpt == m_exm.xpt) else flag_value("xpt", xpt, m_exm.xpt);
      assert (vex == (m_exm.pex & ext_mode))
        else flag_value("vex", vex, m_exm.pex & ext_mode);
      assert (priv_viol == m_viol) else flag_value("priv_viol", priv_viol, m_viol);
      assert (pt_ref.valid == m_ref.valid)
        else flag_value("pt_ref.valid", pt_ref.valid, m_ref.valid);
      if (m_ref.valid) begin
        assert (pt_ref == m_ref) else flag_value("pt_ref", pt_ref, m_ref);
      end
      if (pt_ref.valid === 1'b1) refs_seen++;
    end
    if (reset) begin
      m_pcr  = '0;
      m_exm  = '0;
      m_seg  = '0;
      m_viol = 1'b0;
      m_ref  = '0;
      armed  = 1'b1;
    end else begin
      priv_ok = !m_pcr.pce || (m_pcr.ring == sup_ring);
      m_ref   = lookup ? expect_ref(m_pcr, m_exm, m_seg, ext_mode, alt, vpage) : '0;
      if (lookup) lookups_sent++;
      m_viol  = (ld_cmd == ld_exm || ld_cmd == ld_pcr) && !priv_ok;
      case (ld_cmd)
        ld_exm:  if (priv_ok) m_exm = exm_t'(fidbo[2:0]);
        ld_pcr:  if (priv_ok) m_pcr = {fidbo[15:7], 4'b0000, fidbo[2:0]};
        ld_seg:  m_seg = fidbo[7:0];
        default: ;
      endcase
    end
  end

  // ************************************************************************
  // stimulus
  // ************************************************************************

  task automatic drive(ld_cmd_e cmd, logic [bus_w-1:0] data, logic lk, logic a,
                       logic [page_w-1:0] vp);
    @(negedge mclk);                             // inputs change on the falling edge.
    ld_cmd = cmd;
    fidbo  = data;
    lookup = lk;
    alt    = a;
    vpage  = vp;
  endtask

  task automatic drive_idle();
    drive(ld_none, $urandom, 1'b0, 1'b0, '0);    // bus noise must not load.
  endtask

  task automatic wait_reset_release(int limit);
    int n;
    n = 0;
    while (reset !== 1'b0 && n < limit) begin
      @(posedge mclk);
      n++;
    end
    if (reset !== 1'b0) begin
      timeouts++;
      $display("timeout: reset still asserted after %0d cycles", limit);
    end
  endtask

  task automatic wait_viol(int limit);
    int n;
    n = 0;
    while (priv_viol !== 1'b1 && n < limit) begin
      drive_idle();
      n++;
    end
    if (priv_viol !== 1'b1) begin
      timeouts++;
      $display("timeout: no privilege violation seen within %0d cycles", limit);
    end
  endtask

  task automatic wait_drain(int limit);
    int n;
    n = 0;
    while (pt_ref.valid !== 1'b0 && n < limit) begin
      drive_idle();
      n++;
    end
    if (pt_ref.valid !== 1'b0) begin
      timeouts++;
      $display("timeout: lookup references still arriving after %0d cycles", limit);
    end
  endtask

  initial begin
    ld_cmd_e          cmd;
    logic [bus_w-1:0] data;
    void'($urandom(20147));
    {ext_mode, lookup, alt, vpage, fidbo} = '0;
    ld_cmd = ld_none;
    {armed, errors, timeouts, lookups_sent, refs_seen} = '0;
    wait_reset_release(20);
    assert ({pcr, seg, seg_zero_n, pex, vex, xpt, priv_viol, pt_ref.valid} == '0)
      else flag_value("reset state",
                      {pcr, seg, seg_zero_n, pex, vex, xpt, priv_viol, pt_ref.valid}, 0);
    drive(ld_exm, 16'hfff5, 1'b0, 1'b0, '0);     // exm takes 101 only.
    drive(ld_seg, 16'h12ab, 1'b0, 1'b0, '0);
    drive(ld_pcr, 16'h7ffe, 1'b0, 1'b0, '0);     // hole bits set on the bus with pce clear.
    drive(ld_seg, 16'hff00, 1'b0, 1'b0, '0);     // segment zero again.
    drive(ld_seg, 16'h0001, 1'b0, 1'b0, '0);
    drive(ld_exm, 16'h0007, 1'b0, 1'b0, '0);     // pex set with xpt 3.
    for (int i = 0; i < 8; i++) begin
      ext_mode = i[0];
      if (i == 4) drive(ld_exm, 16'h0006, 1'b0, 1'b0, '0);  // pex off while xpt is kept.
      drive(ld_none, $urandom, 1'b1, i[1], 6'(i * 7));
    end
    for (int i = 0; i < 200; i++) begin          // random streaming.
      cmd  = ld_cmd_e'($urandom_range(0, 3));
      data = $urandom;
      if (cmd == ld_pcr) data[15] = 1'b0;        // paging stays off here.
      ext_mode = $urandom_range(0, 1);
      drive(cmd, data, $urandom_range(0, 3) != 0, $urandom_range(0, 1),
            $urandom_range(0, 63));
    end
    wait_drain(8);
    drive(ld_pcr, 16'h8003, 1'b0, 1'b0, '0);     // paging on in ring 3.
    drive(ld_exm, 16'h0003, 1'b1, 1'b0, 6'h11);  // granted in ring 3.
    drive(ld_pcr, 16'h8181, 1'b1, 1'b1, 6'h22);  // drop to ring 1.
    drive(ld_exm, 16'h0004, 1'b1, 1'b0, 6'h33);  // refused.
    wait_viol(4);
    drive(ld_pcr, 16'h8003, 1'b0, 1'b0, '0);     // refused since ring 1 cannot climb back.
    wait_viol(4);
    drive(ld_seg, 16'h005a, 1'b1, 1'b1, 6'h3f);  // granted while the lookup sees the old seg.
    drive(ld_none, 16'h0000, 1'b1, 1'b0, 6'h01);
    wait_drain(8);
    drive_idle();
    assert (refs_seen == lookups_sent)
      else flag_value("reference count", refs_seen, lookups_sent);
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mac_top.f
rtl/mac_cfg_pkg.sv
rtl/mac_regs_pkg.sv
rtl/mac_load_decode.sv
rtl/mac_segpt.sv
rtl/mac_pt_select.sv
rtl/mac_top.sv
test/tb_clock.sv
test/tb_mac_top.sv

//--- Bender.yml
package:
  name: mac_segpt

sources:
  - rtl/mac_cfg_pkg.sv
  - rtl/mac_regs_pkg.sv
  - rtl/mac_load_decode.sv
  - rtl/mac_segpt.sv
  - rtl/mac_pt_select.sv
  - rtl/mac_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_mac_top.sv
